/* hw/cbm2_pkg.sv */
`default_nettype none

package cbm2_pkg;

	// ==============================
	// Basic types
	// ==============================

	typedef logic [24:0] mem_addr_t;
	typedef logic [7:0]  byte_t;
	typedef logic [1:0]  ram_size_t;  // 0 256K, 1 128K, 2 1M
	typedef logic [7:0]  rom_mask_t;
	typedef logic [16:0] rst_cnt_t;

	typedef enum logic [1:0] {
		ERASE_NONE,
		ERASE_SEG15,
		ERASE_ALL
	} erase_mode_t;

	typedef enum logic {
		DW_STREAM,
		DW_INJECT
	} dw_state_t;

	// Raw menu fields
	typedef struct packed {
		logic [2:0] system_sel;
		logic [1:0] custom_model;  // 0 high profile, 1 low profile, 2 P model
		ram_size_t  custom_ram;
		logic       tv_ntsc;
		logic       clear_seg15_only;
		logic       release_keys;
	} sys_cfg_t;

	typedef struct packed {
		logic      model_b;
		logic      profile_hi;
		ram_size_t ram_size;
		logic      ntsc;
	} model_t;

	typedef struct packed {
		logic       download;
		logic [5:0] index;
		logic       wr;
		mem_addr_t  addr;
		byte_t      data;
	} dl_bus_t;

	typedef struct packed {
		logic      ce;
		logic      we;
		mem_addr_t addr;
		byte_t     data;
	} mem_req_t;

	typedef struct packed {
		logic        wr;
		logic [11:0] addr;
		logic [15:0] data;
	} sid_ld_t;

	// ==============================
	// Constants
	// ==============================

	localparam logic [5:0] IDX_ROM_E = 6'd2;
	localparam logic [5:0] IDX_ROM_C = 6'd3;
	localparam logic [5:0] IDX_ROM_8 = 6'd4;
	localparam logic [5:0] IDX_ROM_6 = 6'd5;
	localparam logic [5:0] IDX_ROM_4 = 6'd6;
	localparam logic [5:0] IDX_ROM_2 = 6'd7;
	localparam logic [5:0] IDX_ROM_1 = 6'd8;
	localparam logic [5:0] IDX_PRG   = 6'd9;
	localparam logic [5:0] IDX_FLT   = 6'd10;

	// Slot base in segment 15, entry n belongs to index IDX_ROM_E + n
	localparam logic [6:0][15:0] ROM_BASE = {
		16'h1000, 16'h2000, 16'h4000, 16'h6000, 16'h8000, 16'hC000, 16'hE000
	};

	localparam logic [8:0] SEG15 = 9'h00F;

	localparam rst_cnt_t HARD_RESET_CYCLES = 17'd100000;
	localparam rst_cnt_t SOFT_RESET_CYCLES = 17'd255;
	localparam rst_cnt_t ERASE_ARM_COUNT   = 17'd100;

	localparam mem_addr_t ERASE_LAST    = 25'h0FD7FF;
	localparam mem_addr_t FLT_MAX_BYTES = 25'd6144;

	// Zero page BASIC pointers
	localparam byte_t TXTTAB = 8'h2D;
	localparam byte_t TXTEND = 8'h2F;

endpackage

`default_nettype wire

/* hw/config_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module config_decode (
	input  wire                     clk_sys,
	input  wire                     RESET,
	input  wire cbm2_pkg::sys_cfg_t cfg,
	output cbm2_pkg::model_t        model
);
	import cbm2_pkg::*;

	logic   m7x0;
	logic   m6x0;
	logic   m500;
	logic   mx10;
	logic   custom;
	model_t next_model;

	assign m7x0   = cfg.system_sel <= 3'd2;
	assign m6x0   = cfg.system_sel >= 3'd3 && cfg.system_sel <= 3'd5;
	assign m500   = cfg.system_sel == 3'd6;
	assign mx10   = cfg.system_sel == 3'd2 || cfg.system_sel == 3'd5;
	assign custom = cfg.system_sel == 3'd7;

	always_comb begin
		next_model.model_b    = custom ? (cfg.custom_model != 2'd2) : (m6x0 | m7x0);
		next_model.profile_hi = custom ? (cfg.custom_model == 2'd0) : m7x0;
		next_model.ram_size   = custom ? cfg.custom_ram : {1'b0, m500 | mx10};
		// 7x0 machines only exist as NTSC
		next_model.ntsc       = cfg.tv_ntsc | m7x0;
	end

	always_ff @(posedge clk_sys) begin
		if (RESET)
			model <= '0;
		else
			model <= next_model;
	end

endmodule

`default_nettype wire

/* hw/reset_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module reset_ctrl (
	input  wire                     clk_sys,
	input  wire                     RESET,
	input  wire cbm2_pkg::sys_cfg_t cfg,
	input  wire cbm2_pkg::model_t   model,
	input  wire                     hard_reset_req,
	input  wire                     soft_reset_req,
	input  wire                     rom_dl_start,
	input  wire                     erase_busy,
	output logic                    reset_n,
	output logic                    erase_req,
	output cbm2_pkg::erase_mode_t   erase_mode,
	output logic                    dl_hold
);
	import cbm2_pkg::*;

	rst_cnt_t    cnt;
	logic [6:0]  sys_r;
	logic        ntsc_r;
	logic        hard_cause;
	logic        soft_cause;
	erase_mode_t reload_mode;

	assign hard_cause = (sys_r != {cfg.system_sel, cfg.custom_model, cfg.custom_ram})
		| hard_reset_req | rom_dl_start;
	assign soft_cause = soft_reset_req | (ntsc_r != model.ntsc);

	// A full erase still pending is never narrowed to segment 15
	assign reload_mode = (erase_mode == ERASE_ALL || !cfg.clear_seg15_only) ?
		ERASE_ALL : ERASE_SEG15;

	always_ff @(posedge clk_sys) begin
		sys_r     <= {cfg.system_sel, cfg.custom_model, cfg.custom_ram};
		ntsc_r    <= model.ntsc;
		erase_req <= 1'b0;
		if (RESET) begin
			cnt        <= HARD_RESET_CYCLES;
			erase_mode <= ERASE_ALL;
			reset_n    <= 1'b0;
			dl_hold    <= 1'b0;
		end else begin
			reset_n <= cnt == '0;
			if (hard_cause) begin
				cnt        <= HARD_RESET_CYCLES;
				erase_mode <= reload_mode;
				if (rom_dl_start)
					dl_hold <= 1'b1;
			end else if (soft_cause) begin
				cnt <= (erase_mode == ERASE_ALL) ? HARD_RESET_CYCLES : SOFT_RESET_CYCLES;
			end else if (!erase_busy) begin
				// Counter stands still while the eraser runs
				if (cnt == '0) begin
					erase_mode <= ERASE_NONE;
					dl_hold    <= 1'b0;
				end else begin
					cnt <= cnt - 1'b1;
					if (cnt == ERASE_ARM_COUNT && erase_mode != ERASE_NONE)
						erase_req <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hw/download_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module download_writer (
	input  wire                     clk_sys,
	input  wire                     RESET,
	input  wire cbm2_pkg::dl_bus_t  dl,
	input  wire cbm2_pkg::model_t   model,
	input  wire                     wr_ack,
	output logic                    wr_pending,
	output cbm2_pkg::mem_req_t      req,
	output cbm2_pkg::rom_mask_t     rom_loaded,
	output logic                    rom_dl_start
);
	import cbm2_pkg::*;

	dw_state_t   state;
	mem_addr_t   load_addr;
	mem_addr_t   rom_addr;
	logic [15:0] inj_start;
	logic [15:0] inj_end;
	logic [15:0] inj_ptr;
	byte_t       inj_off;
	byte_t       inj_data;
	logic        old_download;
	logic        is_prg;
	logic        is_rom;
	logic        rom_more;
	logic [2:0]  rom_slot;

	assign is_prg   = dl.index == IDX_PRG;
	assign is_rom   = dl.index >= IDX_ROM_E && dl.index <= IDX_ROM_1;
	assign rom_slot = 3'(dl.index - IDX_ROM_E);

	// Byte 0 opens the slot, later bytes follow on in segment 15 outside page D
	assign rom_more = load_addr[24:16] == SEG15 && load_addr[15:12] != 4'hD;
	assign rom_addr = (dl.addr == '0) ? {SEG15, ROM_BASE[rom_slot]} : load_addr;

	assign rom_dl_start = dl.wr && is_rom && dl.addr == '0;

	// Offsets 2D..30 hold start lo, start hi, end lo, end hi
	assign inj_ptr  = (inj_off < TXTEND) ? inj_start : inj_end;
	assign inj_data = (inj_off == TXTTAB || inj_off == TXTEND) ? inj_ptr[7:0] : inj_ptr[15:8];

	always_ff @(posedge clk_sys) begin
		old_download <= dl.download;
		if (RESET) begin
			state      <= DW_STREAM;
			wr_pending <= 1'b0;
			rom_loaded <= '0;
		end else begin
			if (wr_ack)
				wr_pending <= 1'b0;

			case (state)
				DW_STREAM: begin
					if (dl.wr && is_prg) begin
						if (dl.addr == 25'd0) begin
							load_addr      <= {(model.model_b ? 9'd1 : 9'd0), 8'h00, dl.data};
							inj_start[7:0] <= dl.data;
							inj_end[7:0]   <= dl.data;
						end else if (dl.addr == 25'd1) begin
							load_addr[15:8] <= dl.data;
							inj_start[15:8] <= dl.data;
							inj_end[15:8]   <= dl.data;
						end else begin
							req        <= '{ce: 1'b1, we: 1'b1, addr: load_addr, data: dl.data};
							wr_pending <= 1'b1;
							load_addr  <= load_addr + 1'b1;
							inj_end    <= inj_end + 1'b1;
						end
					end

					if (dl.wr && is_rom && (dl.addr == '0 || rom_more)) begin
						req        <= '{ce: 1'b1, we: 1'b1, addr: rom_addr, data: dl.data};
						wr_pending <= 1'b1;
						load_addr  <= rom_addr + 1'b1;
						// Blank bytes do not count as a loaded ROM
						if (dl.data != 8'h00 && dl.data != 8'hFF)
							rom_loaded[rom_addr[15:13]] <= 1'b1;
					end

					if (old_download && !dl.download && is_prg) begin
						state   <= DW_INJECT;
						inj_off <= TXTTAB;
					end
				end

				DW_INJECT: begin
					if (!wr_pending) begin
						req        <= '{ce: 1'b1, we: 1'b1, addr: {SEG15, 8'h00, inj_off},
							data: inj_data};
						wr_pending <= 1'b1;
						inj_off    <= inj_off + 1'b1;
						if (inj_off == TXTEND + 8'd1)
							state <= DW_STREAM;
					end
				end

				default: state <= DW_STREAM;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/ram_eraser.sv */
`timescale 1ns/1ps
`default_nettype none

module ram_eraser (
	input  wire                        clk_sys,
	input  wire                        RESET,
	input  wire                        erase_req,
	input  wire cbm2_pkg::erase_mode_t erase_mode,
	input  wire cbm2_pkg::model_t      model,
	input  wire cbm2_pkg::rom_mask_t   rom_loaded,
	input  wire                        wr_ack,
	output logic                       busy,
	output logic                       wr_pending,
	output cbm2_pkg::mem_req_t         req
);
	import cbm2_pkg::*;

	erase_mode_t mode_r;
	mem_addr_t   addr;
	mem_addr_t   last_ram;
	mem_addr_t   skip_to;
	logic        skip;
	logic        in_seg15;
	byte_t       fill;

	assign in_seg15 = addr[24:16] == SEG15;

	// Last byte of normal RAM
	// A 1M machine has no gap before segment 15
	always_comb begin
		case ({model.ram_size, model.model_b})
			3'b010:  last_ram = 25'h01FFFF;
			3'b011:  last_ram = 25'h02FFFF;
			3'b000:  last_ram = 25'h03FFFF;
			3'b001:  last_ram = 25'h04FFFF;
			default: last_ram = '1;
		endcase
	end

	// ==============================
	// Segment 15 holes
	// ==============================

	always_comb begin
		skip    = 1'b0;
		skip_to = addr;
		if (mode_r == ERASE_ALL && in_seg15) begin
			skip = 1'b1;
			if (addr[15:12] == 4'h1 && rom_loaded[0])
				skip_to = {SEG15, 16'h2000};
			else if (addr[15:13] == 3'b001 && rom_loaded[1])
				skip_to = {SEG15, 16'h4000};
			else if (addr[15:13] == 3'b010 && rom_loaded[2])
				skip_to = {SEG15, 16'h6000};
			else if (addr[15:13] == 3'b011 && rom_loaded[3])
				skip_to = {SEG15, 16'h8000};
			else if (addr[15:14] == 2'b10)
				skip_to = {SEG15, 16'hC000};
			else if (addr[15:12] == 4'hC && rom_loaded[6])
				skip_to = {SEG15, 16'hD000};
			else
				skip = 1'b0;
		end
	end

	assign fill = in_seg15 ? {8{addr[6]}} : {8{addr[14] ^ addr[3] ^ addr[2]}};

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			busy       <= 1'b0;
			wr_pending <= 1'b0;
		end else begin
			if (wr_ack)
				wr_pending <= 1'b0;

			if (!busy) begin
				if (erase_req && erase_mode != ERASE_NONE) begin
					busy   <= 1'b1;
					mode_r <= erase_mode;
					if (erase_mode == ERASE_SEG15)
						addr <= {SEG15, 16'h0000};
					else
						addr <= model.model_b ? 25'h010000 : 25'h000000;
				end
			end else if (!wr_pending) begin
				if (mode_r == ERASE_SEG15 && addr > {SEG15, 16'h0FFF}) begin
					busy <= 1'b0;
				end else if (skip) begin
					addr <= skip_to;
				end else if (addr > ERASE_LAST) begin
					busy <= 1'b0;
				end else begin
					req        <= '{ce: 1'b1, we: 1'b1, addr: addr, data: fill};
					wr_pending <= 1'b1;
					addr       <= (addr == last_ram) ? {SEG15, 16'h0000} : addr + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hw/mem_port.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_port (
	input  wire                     clk_sys,
	input  wire                     RESET,
	input  wire                     io_cycle,
	input  wire                     erase_pending,
	input  wire cbm2_pkg::mem_req_t erase_req,
	input  wire                     dl_pending,
	input  wire cbm2_pkg::mem_req_t dl_req,
	input  wire cbm2_pkg::mem_req_t cpu_req,
	output logic                    erase_ack,
	output logic                    dl_ack,
	output cbm2_pkg::mem_req_t      mem_req
);
	import cbm2_pkg::*;

	logic     io_d;
	logic     io_fall;
	logic     io_rise;
	mem_req_t ldr;

	assign io_fall = !io_cycle && io_d;
	assign io_rise = io_cycle && !io_d;

	// Loader access lives from the fall of io_cycle to its next rise
	always_ff @(posedge clk_sys) begin
		io_d      <= io_cycle;
		erase_ack <= 1'b0;
		dl_ack    <= 1'b0;
		if (RESET) begin
			ldr.ce <= 1'b0;
			ldr.we <= 1'b0;
		end else if (io_fall) begin
			// Idle window still runs a read
			ldr.ce <= 1'b1;
			ldr.we <= 1'b0;
			if (erase_pending) begin
				ldr       <= erase_req;
				erase_ack <= 1'b1;
			end else if (dl_pending) begin
				ldr    <= dl_req;
				dl_ack <= 1'b1;
			end
		end else if (io_rise) begin
			ldr.ce <= 1'b0;
			ldr.we <= 1'b0;
		end
	end

	assign mem_req = io_cycle ? cpu_req : ldr;

endmodule

`default_nettype wire

/* hw/flt_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module flt_loader (
	input  wire                    clk_sys,
	input  wire                    RESET,
	input  wire cbm2_pkg::dl_bus_t dl,
	output cbm2_pkg::sid_ld_t      sid_ld
);
	import cbm2_pkg::*;

	logic        ld_wr;
	logic [11:0] ld_addr;
	logic [15:0] ld_data;
	logic        take;

	assign take = dl.wr && dl.index == IDX_FLT && dl.addr < FLT_MAX_BYTES;

	always_ff @(posedge clk_sys) begin
		if (RESET)
			ld_wr <= 1'b0;
		else
			ld_wr <= take && dl.addr[0];
	end

	// Low byte first, the odd byte completes the word
	always_ff @(posedge clk_sys) begin
		if (take) begin
			if (dl.addr[0]) begin
				ld_data[15:8] <= dl.data;
				ld_addr       <= dl.addr[12:1];
			end else begin
				ld_data[7:0] <= dl.data;
			end
		end
	end

	assign sid_ld = '{wr: ld_wr, addr: ld_addr, data: ld_data};

endmodule

`default_nettype wire

/* hw/cbm2_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module cbm2_loader (
	input  wire                     clk_sys,
	input  wire                     RESET,
	input  wire cbm2_pkg::sys_cfg_t cfg,
	input  wire                     hard_reset_req,
	input  wire                     soft_reset_req,
	input  wire cbm2_pkg::dl_bus_t  dl,
	input  wire                     io_cycle,
	input  wire cbm2_pkg::mem_req_t cpu_req,
	output logic                    dl_wait,
	output logic                    reset_n,
	output cbm2_pkg::mem_req_t      mem_req,
	output cbm2_pkg::rom_mask_t     rom_loaded,
	output cbm2_pkg::sid_ld_t       sid_ld
);
	import cbm2_pkg::*;

	model_t      model;
	erase_mode_t erase_mode;
	logic        erase_start;
	logic        erase_busy;
	logic        erase_pending;
	logic        erase_ack;
	mem_req_t    erase_wr;
	logic        dl_hold;
	logic        rom_dl_start;
	logic        dl_pending;
	logic        dl_ack;
	mem_req_t    dl_wr;

	// ==============================
	// Configuration and reset
	// ==============================

	config_decode config_decode_i (
		.clk_sys (clk_sys),
		.RESET   (RESET),
		.cfg     (cfg),
		.model   (model)
	);

	reset_ctrl reset_ctrl_i (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.cfg            (cfg),
		.model          (model),
		.hard_reset_req (hard_reset_req),
		.soft_reset_req (soft_reset_req),
		.rom_dl_start   (rom_dl_start),
		.erase_busy     (erase_busy),
		.reset_n        (reset_n),
		.erase_req      (erase_start),
		.erase_mode     (erase_mode),
		.dl_hold        (dl_hold)
	);

	// ==============================
	// Loader sources
	// ==============================

	download_writer download_writer_i (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.dl           (dl),
		.model        (model),
		.wr_ack       (dl_ack),
		.wr_pending   (dl_pending),
		.req          (dl_wr),
		.rom_loaded   (rom_loaded),
		.rom_dl_start (rom_dl_start)
	);

	ram_eraser ram_eraser_i (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.erase_req  (erase_start),
		.erase_mode (erase_mode),
		.model      (model),
		.rom_loaded (rom_loaded),
		.wr_ack     (erase_ack),
		.busy       (erase_busy),
		.wr_pending (erase_pending),
		.req        (erase_wr)
	);

	flt_loader flt_loader_i (
		.clk_sys (clk_sys),
		.RESET   (RESET),
		.dl      (dl),
		.sid_ld  (sid_ld)
	);

	// Host stalls on a queued byte or during a ROM download reset
	assign dl_wait = dl_pending | dl_hold;

	mem_port mem_port_i (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.io_cycle      (io_cycle),
		.erase_pending (erase_pending),
		.erase_req     (erase_wr),
		.dl_pending    (dl_pending),
		.dl_req        (dl_wr),
		.cpu_req       (cpu_req),
		.erase_ack     (erase_ack),
		.dl_ack        (dl_ack),
		.mem_req       (mem_req)
	);

endmodule

`default_nettype wire

/* test/loader_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module loader_checker (
	input  wire                     clk_sys,
	input  wire                     RESET,
	input  wire                     io_cycle,
	input  wire cbm2_pkg::mem_req_t cpu_req,
	input  wire cbm2_pkg::mem_req_t mem_req,
	input  wire cbm2_pkg::sid_ld_t  sid_ld,
	output int                      error_count
);
	import cbm2_pkg::*;

	byte_t   ram_model [int unsigned];
	byte_t   shadow [int unsigned];
	sid_ld_t sid_expect [$];
	sid_ld_t sid_head;
	int      test_checks;
	int      test_errors;
	int      total_checks;
	int      tests_run;
	int      tests_failed;

	initial begin
		error_count  = 0;
		test_checks  = 0;
		test_errors  = 0;
		total_checks = 0;
		tests_run    = 0;
		tests_failed = 0;
	end

	// ==============================
	// Reference rules
	// ==============================

	function automatic byte_t fill_ref(input mem_addr_t a);
		if (a[24:16] == 9'h00F)
			return {8{a[6]}};
		return {8{a[14] ^ a[3] ^ a[2]}};
	endfunction

	// F8000..FBFFF is never cleared
	task automatic shadow_fill(input mem_addr_t lo, input mem_addr_t hi);
		mem_addr_t a;
		for (a = lo; a <= hi; a++) begin
			if (!(a >= 25'h0F8000 && a <= 25'h0FBFFF))
				shadow[32'(a)] = fill_ref(a);
		end
	endtask

	task automatic shadow_byte(input mem_addr_t a, input byte_t d);
		shadow[32'(a)] = d;
	endtask

	task automatic expect_sid(input logic [11:0] a, input logic [15:0] d);
		sid_ld_t w;
		w = '{wr: 1'b1, addr: a, data: d};
		sid_expect.push_back(w);
	endtask

	task automatic note_error();
		test_errors++;
		error_count++;
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		test_checks++;
		if (exp !== act) begin
			note_error();
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
		end
	endtask

	// ==============================
	// RAM comparison
	// ==============================

	task automatic compare_ram(input string name);
		int shown;
		shown = 0;
		foreach (shadow[a]) begin
			test_checks++;
			if (!ram_model.exists(a)) begin
				note_error();
				shown++;
				if (shown <= 8)
					$display("%s: address %h was never written", name, a);
			end else if (ram_model[a] !== shadow[a]) begin
				note_error();
				shown++;
				if (shown <= 8)
					$display("MISMATCH %s at %h expected %h actual %h",
						name, a, shadow[a], ram_model[a]);
			end
		end
		foreach (ram_model[a]) begin
			if (!shadow.exists(a)) begin
				note_error();
				shown++;
				if (shown <= 8)
					$display("%s: unexpected write at address %h", name, a);
			end
		end
	endtask

	task automatic end_test(input string name);
		if (sid_expect.size() != 0) begin
			note_error();
			$display("%s: %0d filter words were never written", name, sid_expect.size());
			sid_expect.delete();
		end
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
		$display("test %-16s %s  checks %0d  errors %0d", name,
			(test_errors == 0) ? "PASS" : "FAIL", test_checks, test_errors);
		total_checks += test_checks;
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic report_totals();
		$display("tests %0d  failed %0d  checks %0d  errors %0d",
			tests_run, tests_failed, total_checks, error_count);
	endtask

	// Memory model, filter words and CPU pass-through
	always @(posedge clk_sys) begin
		if (!RESET) begin
			if (mem_req.ce && mem_req.we)
				ram_model[32'(mem_req.addr)] = mem_req.data;
			if (io_cycle) begin
				test_checks++;
				if (mem_req !== cpu_req) begin
					note_error();
					$display("MISMATCH cpu_passthrough expected %h actual %h", cpu_req, mem_req);
				end
			end
			if (sid_ld.wr) begin
				test_checks++;
				if (sid_expect.size() == 0) begin
					note_error();
					$display("Filter word written at %h when none was due", sid_ld.addr);
				end else begin
					sid_head = sid_expect.pop_front();
					if ({sid_head.addr, sid_head.data} !== {sid_ld.addr, sid_ld.data}) begin
						note_error();
						$display("MISMATCH flt_word expected %h:%h actual %h:%h",
							sid_head.addr, sid_head.data, sid_ld.addr, sid_ld.data);
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

/* test/tb_cbm2_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cbm2_loader;
	import cbm2_pkg::*;

	// The last 16 ROM bytes would fall in page D
	localparam int ROM_BYTES      = 'hB000 + 16;
	localparam int PRG_BODY       = 64;
	localparam int FLT_BYTES      = 6152;
	localparam int WRITE_TOTAL    = 169984 + 3 * 4096 + ROM_BYTES + PRG_BODY + 4 + FLT_BYTES;
	localparam int TIMEOUT_CYCLES = 2 * WRITE_TOTAL * 8 + 4 * int'(HARD_RESET_CYCLES) + 10;

	logic        clk_sys;
	logic        RESET;
	sys_cfg_t    cfg;
	logic        hard_reset_req;
	logic        soft_reset_req;
	dl_bus_t     dl;
	logic        io_cycle;
	mem_req_t    cpu_req;
	logic        dl_wait;
	logic        reset_n;
	mem_req_t    mem_req;
	rom_mask_t   rom_loaded;
	sid_ld_t     sid_ld;
	int          error_count;
	int          cycle_count;
	logic [31:0] lfsr;
	byte_t       payload [$];

	cbm2_loader cbm2_loader_i (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.cfg            (cfg),
		.hard_reset_req (hard_reset_req),
		.soft_reset_req (soft_reset_req),
		.dl             (dl),
		.io_cycle       (io_cycle),
		.cpu_req        (cpu_req),
		.dl_wait        (dl_wait),
		.reset_n        (reset_n),
		.mem_req        (mem_req),
		.rom_loaded     (rom_loaded),
		.sid_ld         (sid_ld)
	);

	loader_checker chk (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.io_cycle    (io_cycle),
		.cpu_req     (cpu_req),
		.mem_req     (mem_req),
		.sid_ld      (sid_ld),
		.error_count (error_count)
	);

	// ==============================
	// Clock, io window, timeout
	// ==============================

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	initial begin
		io_cycle = 1'b1;
		forever begin
			repeat (4) @(posedge clk_sys);
			#1 io_cycle = ~io_cycle;
		end
	end

	initial cycle_count = 0;

	always @(posedge clk_sys) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Something failed");
			$finish;
		end
	end

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [63:0] random_bits(input int n);
		logic [63:0] v;
		logic        fb;
		v = '0;
		for (int k = 0; k < n; k++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = {v[62:0], fb};
		end
		return v;
	endfunction

	// ==============================
	// Stimulus tasks
	// ==============================

	// One byte per strobe and none while dl_wait is high
	task automatic send_payload(input logic [5:0] index);
		int i;
		@(posedge clk_sys);
		#1;
		dl.download = 1'b1;
		dl.index    = index;
		for (i = 0; i < payload.size(); i++) begin
			dl.wr   = 1'b1;
			dl.addr = 25'(i);
			dl.data = payload[i];
			@(posedge clk_sys);
			#1 dl.wr = 1'b0;
			@(posedge clk_sys);
			while (dl_wait)
				@(posedge clk_sys);
			#1;
		end
		dl.download = 1'b0;
	endtask

	task automatic wait_reset_cycle();
		@(posedge clk_sys);
		while (reset_n)
			@(posedge clk_sys);
		while (!reset_n)
			@(posedge clk_sys);
	endtask

	task automatic wait_for_write(input mem_addr_t a);
		@(posedge clk_sys);
		while (!(mem_req.ce && mem_req.we && mem_req.addr == a))
			@(posedge clk_sys);
	endtask

	// Two io windows for a final write to land
	task automatic settle();
		repeat (16) @(posedge clk_sys);
		#1;
	endtask

	initial begin
		rom_mask_t   rom_expect;
		logic [15:0] rom_addr;
		logic [15:0] prg_end;
		int          i;
		lfsr           = 32'h75764deb;
		RESET          = 1'b1;
		cfg            = '{system_sel: 3'd6, custom_model: 2'd0, custom_ram: 2'd0,
			tv_ntsc: 1'b0, clear_seg15_only: 1'b0, release_keys: 1'b0};
		hard_reset_req = 1'b0;
		soft_reset_req = 1'b0;
		dl             = '0;
		cpu_req        = '0;
		repeat (10) @(posedge clk_sys);
		#1 RESET = 1'b0;

		// Full erase of a 128K P model after power-on
		wait_for_write(ERASE_LAST);
		chk.check_value("reset_hold", 32'd0, 32'(reset_n));
		while (!reset_n)
			@(posedge clk_sys);
		chk.shadow_fill(25'h000000, 25'h01FFFF);
		chk.shadow_fill(25'h0F0000, 25'h0FD7FF);
		chk.compare_ram("full_erase");
		chk.end_test("full_erase");

		// Move to a 128K B model that clears segment 15 only
		#1;
		cfg.system_sel       = 3'd5;
		cfg.clear_seg15_only = 1'b1;
		wait_reset_cycle();
		chk.shadow_fill(25'h0F0000, 25'h0F0FFF);

		payload.delete();
		rom_expect = '0;
		for (i = 0; i < ROM_BYTES; i++) begin
			payload.push_back(8'(random_bits(8)));
			rom_addr = 16'h2000 + 16'(i);
			if (rom_addr < 16'hD000) begin
				chk.shadow_byte({9'h00F, rom_addr}, payload[i]);
				if (payload[i] != 8'h00 && payload[i] != 8'hFF)
					rom_expect[rom_addr[15:13]] = 1'b1;
			end
		end
		send_payload(IDX_ROM_2);
		settle();
		chk.compare_ram("rom_image");
		chk.check_value("rom_loaded", 32'(rom_expect), 32'(rom_loaded));
		chk.end_test("rom_image");

		// PRG at $0401 with pointers in zero page of segment 15
		payload.delete();
		payload.push_back(8'h01);
		payload.push_back(8'h04);
		for (i = 0; i < PRG_BODY; i++) begin
			payload.push_back(8'(random_bits(8)));
			chk.shadow_byte(25'h010401 + 25'(i), payload[i + 2]);
		end
		prg_end = 16'h0401 + 16'(PRG_BODY);
		chk.shadow_byte(25'h0F002D, 8'h01);
		chk.shadow_byte(25'h0F002E, 8'h04);
		chk.shadow_byte(25'h0F002F, prg_end[7:0]);
		chk.shadow_byte(25'h0F0030, prg_end[15:8]);
		send_payload(IDX_PRG);
		wait_for_write(25'h0F0030);
		settle();
		chk.compare_ram("prg_load");
		chk.end_test("prg_load");

		hard_reset_req = 1'b1;
		@(posedge clk_sys);
		#1 hard_reset_req = 1'b0;
		wait_reset_cycle();
		chk.shadow_fill(25'h0F0000, 25'h0F0FFF);
		settle();
		chk.compare_ram("seg15_erase");
		chk.end_test("seg15_erase");

		// Filter table words stop at the byte limit
		payload.delete();
		for (i = 0; i < FLT_BYTES; i++)
			payload.push_back(8'(random_bits(8)));
		for (i = 0; i < int'(FLT_MAX_BYTES); i += 2)
			chk.expect_sid(12'(i / 2), {payload[i + 1], payload[i]});
		send_payload(IDX_FLT);
		settle();
		chk.end_test("filter_table");

		repeat (64) begin
			@(posedge clk_sys);
			#1 cpu_req = mem_req_t'(35'(random_bits(35)));
		end
		@(posedge clk_sys);
		#1 cpu_req = '0;
		settle();
		chk.end_test("cpu_passthrough");

		chk.report_totals();
		if (error_count == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

/* cbm2_loader.f */
hw/cbm2_pkg.sv
hw/config_decode.sv
hw/reset_ctrl.sv
hw/download_writer.sv
hw/ram_eraser.sv
hw/mem_port.sv
hw/flt_loader.sv
hw/cbm2_loader.sv
test/loader_checker.sv
test/tb_cbm2_loader.sv

/* Makefile */
# Verilator simulation of the CBM-II loader

VERILATOR ?= verilator
TOP       ?= tb_cbm2_loader
RTL_TOP   ?= cbm2_loader
FILELIST  ?= cbm2_loader.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Everything OK
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
LINTFLAGS ?= --lint-only -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
